// ==== filelist.f ====
source/vdu_regmap_pkg.sv
source/vdu_timing_pkg.sv
source/reg_write_decode.sv
source/banked_field.sv
source/har_counter.sv
source/vdu_register_file.sv
source/raster_timer.sv
source/vdu_control_top.sv
verification/vdu_control_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module vdu_control_tb \
   -f filelist.f -o vdu_sim
./obj_dir/vdu_sim | tee sim.log

if grep -q "TEST OK" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

// ==== verification/vdu_control_tb.sv ====
module vdu_control_tb
   import vdu_regmap_pkg::*, vdu_timing_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CHAR_CLKS   = 4;
   localparam int LINE_CHARS  = 8;
   localparam int FRAME_LINES = 6;
   localparam int FRAME_CLKS  = CHAR_CLKS * LINE_CHARS * FRAME_LINES;
   // Two frames plus two characters
   localparam int IRQ_RUN     = 2 * FRAME_CLKS + 2 * CHAR_CLKS;
   // Tests run for under 3000 cycles
   localparam int CYCLE_LIMIT = 4000;

   logic          clk;
   logic          reset;
   logic          devsel;
   logic          wr;
   logic          rd;
   logic [3:0]    addr;
   logic [15:0]   wdata;
   logic          altmode;
   logic [15:0]   rdata;
   logic          rdata_valid;
   logic          irq;
   logic          vduen;
   logic          irqscl;
   logic          irqvs;
   logic          sen;
   logic [7:0]    scl;
   mode_field_t   mode;
   scroll_field_t scroll;
   logic [5:0]    cbg;
   logic [5:0]    cfg;
   logic [1:0]    cbc;
   logic [15:0]   sar;
   logic [15:0]   mar;
   logic [15:0]   car;
   logic [15:0]   har;

   logic [15:0]   shadow [16];
   logic [15:0]   pending_word;
   logic [3:0]    pending_addr;
   int            reads_issued;
   int            reads_done;
   int            irq_count;
   int            cycle_count;
   integer        seed;

   vdu_control_top #(
      .CHAR_CLKS(CHAR_CLKS), .LINE_CHARS(LINE_CHARS), .FRAME_LINES(FRAME_LINES)
   ) i_dut (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   //////////////////////////////
   // Reference and checks
   //////////////////////////////
   // Expected read-back keeps only the defined bits of each word
   function automatic logic [15:0] model_read(input logic [3:0] a);
      logic [15:0] mask;
      case (a)
         REG_MCR0:           mask = 16'h80FF;
         REG_MCR1:           mask = 16'hFFBF;
         REG_SCR0, REG_SCR1: mask = 16'h00F7;
         REG_CCR:            mask = 16'h3FFF;
         REG_SAR0, REG_SAR1, REG_MAR0, REG_MAR1, REG_CAR, REG_HAR: mask = 16'hFFFF;
         default:            mask = 16'h0000;
      endcase
      return shadow[a] & mask;
   endfunction

   // Interrupts over n enabled cycles with one candidate per line change
   function automatic int expected_irqs(input int n, input logic vs, input logic scl_on,
                                        input int scl_line);
      int lines;
      int count;
      int new_line;
      int k;
      lines = (n / CHAR_CLKS) / LINE_CHARS;
      count = 0;
      for (k = 1; k <= lines; k++) begin
         new_line = k % FRAME_LINES;
         if ((vs && new_line == 0) || (scl_on && new_line == scl_line)) begin
            count++;
         end
      end
      return count;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input logic [15:0] got, input logic [15:0] exp,
                              input string what);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
         $display("TEST FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // Display-side ports rebuilt from the shadow words
   task automatic check_field_ports();
      check_value({vduen, irqscl, irqvs, sen, 4'd0, scl},
                  {shadow[REG_MCR0][15], shadow[REG_MCR0][7:6], shadow[REG_MCR1][7],
                   4'd0, shadow[REG_MCR1][15:8]}, "mcr flag ports");
      check_value({2'd0, cbg, cbc, cfg}, shadow[REG_CCR] & 16'h3FFF, "ccr ports");
      check_value(car, shadow[REG_CAR], "car port");
      check_value(har, shadow[REG_HAR], "har port");
   endtask

   // Compare process for the one read in flight
   initial begin : compare_reads
      forever begin
         @(negedge clk);
         if (rdata_valid) begin
            if (reads_done == reads_issued) begin
               abort_run("rdata_valid came without a pending read");
            end else begin
               check_value(rdata, pending_word,
                           $sformatf("read of address %0d", pending_addr));
               reads_done++;
            end
         end
      end
   end

   always @(negedge clk) begin
      if (irq) begin
         irq_count++;
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count == CYCLE_LIMIT) begin
         abort_run($sformatf("Timeout after %0d cycles", CYCLE_LIMIT));
      end
   end

   //////////////////////////////
   // Bus tasks
   //////////////////////////////
   task automatic write_reg(input logic [3:0] a, input logic [15:0] d);
      @(negedge clk);
      devsel = 1'b1;
      wr     = 1'b1;
      addr   = a;
      wdata  = d;
      shadow[a] = d;
      @(negedge clk);
      devsel = 1'b0;
      wr     = 1'b0;
   endtask

   task automatic await_rdata(input logic [3:0] a);
      int waited;
      waited = 0;
      while (reads_done != reads_issued && waited < 4) begin
         @(negedge clk);
         waited++;
      end
      if (reads_done != reads_issued) begin
         abort_run($sformatf("No rdata_valid after a read of address %0d", a));
      end
   endtask

   task automatic read_reg(input logic [3:0] a);
      @(negedge clk);
      devsel = 1'b1;
      rd     = 1'b1;
      addr   = a;
      pending_word = model_read(a);
      pending_addr = a;
      reads_issued++;
      @(negedge clk);
      devsel = 1'b0;
      rd     = 1'b0;
      await_rdata(a);
   endtask

   // A read that collides with a write returns the old word
   task automatic write_read_reg(input logic [3:0] a, input logic [15:0] d);
      @(negedge clk);
      devsel = 1'b1;
      wr     = 1'b1;
      rd     = 1'b1;
      addr   = a;
      wdata  = d;
      pending_word = model_read(a);
      pending_addr = a;
      reads_issued++;
      shadow[a] = d;
      @(negedge clk);
      devsel = 1'b0;
      wr     = 1'b0;
      rd     = 1'b0;
      await_rdata(a);
   endtask

   // Unit enabled for exactly n cycles between the two write edges
   task automatic run_enabled(input int n, input logic [15:0] flags);
      write_reg(REG_MCR0, flags | 16'h8000);
      repeat (n - 2) @(negedge clk);
      write_reg(REG_MCR0, flags);
   endtask

   task automatic check_har_run(input logic [15:0] load, input int n);
      int pulses;
      int x_exp;
      int y_exp;
      write_reg(REG_HAR, load);
      read_reg(REG_HAR);
      run_enabled(n, 16'h0000);
      pulses = n / CHAR_CLKS;
      x_exp  = (int'(load[6:0]) + pulses) % 128;
      y_exp  = (int'(load[15:7]) + pulses / LINE_CHARS) % 512;
      shadow[REG_HAR] = {9'(y_exp), 7'(x_exp)};
      read_reg(REG_HAR);
   endtask

   task automatic count_irqs(input logic [15:0] mcr0_flags, input logic [15:0] mcr1_word,
                             input string what);
      int start;
      int exp_count;
      write_reg(REG_MCR1, mcr1_word);
      start = irq_count;
      run_enabled(IRQ_RUN, mcr0_flags);
      repeat (2) @(negedge clk);
      exp_count = expected_irqs(IRQ_RUN, mcr0_flags[MCR_IRQVS],
                                mcr0_flags[MCR_IRQSCL] && mcr1_word[MCR_SEN],
                                int'(mcr1_word[15:8]));
      check_value(16'(irq_count - start), 16'(exp_count), what);
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////
   initial begin : main_sequence
      logic [3:0]  a;
      logic [15:0] d;
      logic [3:0]  mb;
      logic [3:0]  sb;
      int          start;
      int          alt;
      int          i;
      reset   = 1'b1;
      devsel  = 1'b0;
      wr      = 1'b0;
      rd      = 1'b0;
      addr    = '0;
      wdata   = '0;
      altmode = 1'b0;
      seed    = 32'h7416a438;
      reads_issued = 0;
      reads_done   = 0;
      irq_count    = 0;
      cycle_count  = 0;
      for (i = 0; i < 16; i++) begin
         shadow[i] = '0;
      end
      repeat (16) @(negedge clk);
      reset = 1'b0;

      // Reset values
      start = irq_count;
      for (i = 0; i < 16; i++) begin
         read_reg(4'(i));
      end
      // Frame interrupt armed while the unit stays off for over a frame
      write_reg(REG_MCR0, 16'h0040);
      repeat (FRAME_CLKS + 2 * CHAR_CLKS) @(negedge clk);
      check_value(16'(vduen), 16'h0000, "vduen after reset");
      check_value(16'(irq_count - start), 16'h0000, "irq while disabled");

      // Random map traffic with the timer stopped so HAR holds
      for (i = 0; i < 200; i++) begin
         a = 4'($random(seed));
         d = 16'($random(seed));
         if (a == REG_MCR0) begin
            d[MCR_VDUEN] = 1'b0;
         end
         if (i[0]) begin
            write_read_reg(a, d);
         end else begin
            write_reg(a, d);
         end
         read_reg(a);
         check_field_ports();
      end

      // Banked fields follow altmode
      write_reg(REG_MCR0, 16'($random(seed)) & 16'h7FFF);
      write_reg(REG_MCR1, 16'($random(seed)));
      write_reg(REG_SCR0, 16'($random(seed)));
      write_reg(REG_SCR1, 16'($random(seed)));
      write_reg(REG_SAR0, 16'h1357);
      write_reg(REG_SAR1, 16'h2468);
      write_reg(REG_MAR0, 16'hace1);
      write_reg(REG_MAR1, 16'hbdf0);
      for (alt = 0; alt < 2; alt++) begin
         altmode = alt[0];
         @(negedge clk);
         mb = alt[0] ? REG_MCR1 : REG_MCR0;
         sb = alt[0] ? REG_SCR1 : REG_SCR0;
         check_value(16'(mode), {10'd0, shadow[mb][5:0]}, "mode bank");
         check_value(16'(scroll), {9'd0, shadow[sb][7:4], shadow[sb][2:0]}, "scroll bank");
         check_value(sar, alt[0] ? 16'h2468 : 16'h1357, "sar bank");
         check_value(mar, alt[0] ? 16'hbdf0 : 16'hace1, "mar bank");
      end
      altmode = 1'b0;

      // HAR load, wrap and counting
      write_reg(REG_HAR, {9'd511, 7'd127});
      read_reg(REG_HAR);
      check_har_run({9'd510, 7'd125}, 205);
      check_har_run(16'h1234, 77);

      // Frame and scanline interrupts
      count_irqs(16'h0040, 16'h0300, "frame irq count");
      count_irqs(16'h00c0, 16'h0380, "frame and scanline irq count");
      count_irqs(16'h00c0, 16'h0300, "irq count with sen clear");

      if (reads_done != reads_issued) begin
         abort_run("A read never returned rdata_valid");
      end else begin
         $display("TEST OK");
         $finish;
      end
   end

endmodule

// ==== source/vdu_control_top.sv ====
module vdu_control_top
   import vdu_timing_pkg::*;
#(
   parameter int CHAR_CLKS   = 4,
   parameter int LINE_CHARS  = 8,
   parameter int FRAME_LINES = 6
) (
   input  logic          clk,
   input  logic          reset,
   input  logic          devsel,
   input  logic          wr,
   input  logic          rd,
   input  logic [3:0]    addr,
   input  logic [15:0]   wdata,
   input  logic          altmode,
   output logic [15:0]   rdata,
   output logic          rdata_valid,
   output logic          irq,
   output logic          vduen,
   output logic          irqscl,
   output logic          irqvs,
   output logic          sen,
   output logic [7:0]    scl,
   output mode_field_t   mode,
   output scroll_field_t scroll,
   output logic [5:0]    cbg,
   output logic [5:0]    cfg,
   output logic [1:0]    cbc,
   output logic [15:0]   sar,
   output logic [15:0]   mar,
   output logic [15:0]   car,
   output logic [15:0]   har
);

   // HAR step strobes from the timer
   logic incx;
   logic incy;

   vdu_register_file i_regs (
      .clk(clk), .reset(reset), .devsel(devsel), .wr(wr), .rd(rd),
      .altmode(altmode), .incx(incx), .incy(incy), .addr(addr), .wdata(wdata),
      .rdata(rdata), .rdata_valid(rdata_valid), .vduen(vduen), .irqscl(irqscl),
      .irqvs(irqvs), .sen(sen), .scl(scl), .mode(mode), .scroll(scroll),
      .cbg(cbg), .cfg(cfg), .cbc(cbc), .sar(sar), .mar(mar), .car(car), .har(har)
   );

   raster_timer #(
      .CHAR_CLKS(CHAR_CLKS), .LINE_CHARS(LINE_CHARS), .FRAME_LINES(FRAME_LINES)
   ) i_timer (
      .clk(clk), .reset(reset), .vduen(vduen), .irqvs(irqvs), .irqscl(irqscl),
      .sen(sen), .scl(scl), .incx(incx), .incy(incy), .irq(irq)
   );

endmodule

// ==== source/raster_timer.sv ====
module raster_timer #(
   parameter int CHAR_CLKS   = 4,
   parameter int LINE_CHARS  = 8,
   parameter int FRAME_LINES = 6
) (
   input  logic       clk,
   input  logic       reset,
   input  logic       vduen,
   input  logic       irqvs,
   input  logic       irqscl,
   input  logic       sen,
   input  logic [7:0] scl,
   output logic       incx,
   output logic       incy,
   output logic       irq
);

   localparam int CLK_W  = $clog2(CHAR_CLKS + 1);
   localparam int CHAR_W = $clog2(LINE_CHARS + 1);
   localparam int LINE_W = $clog2(FRAME_LINES + 1);

   logic [CLK_W-1:0]  clk_cnt;
   logic [CHAR_W-1:0] char_cnt;
   logic [LINE_W-1:0] line_cnt;
   logic              char_end;
   logic              line_end;
   logic              line_hit;

   assign char_end = (clk_cnt == CLK_W'(CHAR_CLKS - 1));
   assign line_end = char_end && (char_cnt == CHAR_W'(LINE_CHARS - 1));

   // line_cnt already holds the new line while incy is high
   assign line_hit = (irqvs && line_cnt == '0) ||
                     (irqscl && sen && 8'(line_cnt) == scl);

   // Whole timer sits idle and cleared while the unit is off
   always_ff @(posedge clk) begin
      if (reset || !vduen) begin
         clk_cnt  <= '0;
         char_cnt <= '0;
         line_cnt <= '0;
         incx     <= 1'b0;
         incy     <= 1'b0;
         irq      <= 1'b0;
      end else begin
         incx <= char_end;
         incy <= line_end;
         irq  <= incy && line_hit;
         clk_cnt <= char_end ? '0 : clk_cnt + 1'b1;
         if (line_end) begin
            char_cnt <= '0;
            // Line number wraps per frame
            if (line_cnt == LINE_W'(FRAME_LINES - 1)) begin
               line_cnt <= '0;
            end else begin
               line_cnt <= line_cnt + 1'b1;
            end
         end else if (char_end) begin
            char_cnt <= char_cnt + 1'b1;
         end
      end
   end

endmodule

// ==== source/vdu_register_file.sv ====
module vdu_register_file
   import vdu_regmap_pkg::*, vdu_timing_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  logic          devsel,
   input  logic          wr,
   input  logic          rd,
   input  logic          altmode,
   input  logic          incx,
   input  logic          incy,
   input  logic [3:0]    addr,
   input  logic [15:0]   wdata,
   output logic [15:0]   rdata,
   output logic          rdata_valid,
   output logic          vduen,
   output logic          irqscl,
   output logic          irqvs,
   output logic          sen,
   output logic [7:0]    scl,
   output mode_field_t   mode,
   output scroll_field_t scroll,
   output logic [5:0]    cbg,
   output logic [5:0]    cfg,
   output logic [1:0]    cbc,
   output logic [15:0]   sar,
   output logic [15:0]   mar,
   output logic [15:0]   car,
   output logic [15:0]   har
);

   logic [15:0]   wr_en;
   logic [3:0]    rd_sel;
   logic          rd_pending;
   logic          wr_during_rd;
   logic [15:0]   pre_write_word;
   logic [15:0]   sel_word;
   logic [15:0]   addr_word;
   mode_field_t   mode_wdata;
   mode_field_t   mode_0;
   mode_field_t   mode_1;
   scroll_field_t scroll_wdata;
   scroll_field_t scroll_0;
   scroll_field_t scroll_1;
   logic [15:0]   sar_0;
   logic [15:0]   sar_1;
   logic [15:0]   mar_0;
   logic [15:0]   mar_1;

   reg_write_decode i_decode (
      .clk(clk), .reset(reset), .devsel(devsel), .wr(wr), .rd(rd), .addr(addr),
      .wr_en(wr_en), .rd_sel(rd_sel), .rd_pending(rd_pending)
   );

   assign mode_wdata   = mode_field_t'(wdata[MCR_MODE_LSB +: $bits(mode_field_t)]);
   assign scroll_wdata = '{vscr: wdata[SCR_VSCR_LSB +: 4], hscr: wdata[SCR_HSCR_LSB +: 3]};

   //////////////////////////////
   // Two-bank fields
   //////////////////////////////
   banked_field #(.payload_t(mode_field_t)) i_mode_bank (
      .clk(clk), .reset(reset), .altmode(altmode),
      .wr_bank0(wr_en[REG_MCR0]), .wr_bank1(wr_en[REG_MCR1]), .wdata(mode_wdata),
      .active(mode), .bank0(mode_0), .bank1(mode_1)
   );

   banked_field #(.payload_t(scroll_field_t)) i_scroll_bank (
      .clk(clk), .reset(reset), .altmode(altmode),
      .wr_bank0(wr_en[REG_SCR0]), .wr_bank1(wr_en[REG_SCR1]), .wdata(scroll_wdata),
      .active(scroll), .bank0(scroll_0), .bank1(scroll_1)
   );

   banked_field #(.payload_t(logic [15:0])) i_sar_bank (
      .clk(clk), .reset(reset), .altmode(altmode),
      .wr_bank0(wr_en[REG_SAR0]), .wr_bank1(wr_en[REG_SAR1]), .wdata(wdata),
      .active(sar), .bank0(sar_0), .bank1(sar_1)
   );

   banked_field #(.payload_t(logic [15:0])) i_mar_bank (
      .clk(clk), .reset(reset), .altmode(altmode),
      .wr_bank0(wr_en[REG_MAR0]), .wr_bank1(wr_en[REG_MAR1]), .wdata(wdata),
      .active(mar), .bank0(mar_0), .bank1(mar_1)
   );

   har_counter i_har (
      .clk(clk), .reset(reset), .load(wr_en[REG_HAR]), .incx(incx), .incy(incy),
      .load_value(wdata), .har(har)
   );

   //////////////////////////////
   // Single-copy fields
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         vduen  <= 1'b0;
         irqscl <= 1'b0;
         irqvs  <= 1'b0;
         scl    <= '0;
         sen    <= 1'b0;
         cbg    <= '0;
         cbc    <= '0;
         cfg    <= '0;
         car    <= '0;
      end else begin
         if (wr_en[REG_MCR0]) begin
            vduen  <= wdata[MCR_VDUEN];
            irqscl <= wdata[MCR_IRQSCL];
            irqvs  <= wdata[MCR_IRQVS];
         end
         if (wr_en[REG_MCR1]) begin
            scl <= wdata[MCR_SCL_LSB +: 8];
            sen <= wdata[MCR_SEN];
         end
         if (wr_en[REG_CCR]) begin
            cbg <= wdata[CCR_CBG_LSB +: 6];
            cbc <= wdata[CCR_CBC_LSB +: 2];
            cfg <= wdata[CCR_CFG_LSB +: 6];
         end
         if (wr_en[REG_CAR]) begin
            car <= wdata;
         end
      end
   end

   //////////////////////////////
   // Read-back
   //////////////////////////////
   // Rebuild a register word from its stored fields, holes read zero
   function automatic logic [15:0] reg_word(input logic [3:0] sel);
      logic [15:0] w;
      w = '0;
      case (sel)
         REG_MCR0: begin
            w[MCR_VDUEN]  = vduen;
            w[MCR_IRQSCL] = irqscl;
            w[MCR_IRQVS]  = irqvs;
            w[MCR_MODE_LSB +: $bits(mode_field_t)] = mode_0;
         end
         REG_MCR1: begin
            w[MCR_SCL_LSB +: 8] = scl;
            w[MCR_SEN]          = sen;
            w[MCR_MODE_LSB +: $bits(mode_field_t)] = mode_1;
         end
         REG_SCR0: begin
            w[SCR_VSCR_LSB +: 4] = scroll_0.vscr;
            w[SCR_HSCR_LSB +: 3] = scroll_0.hscr;
         end
         REG_SCR1: begin
            w[SCR_VSCR_LSB +: 4] = scroll_1.vscr;
            w[SCR_HSCR_LSB +: 3] = scroll_1.hscr;
         end
         REG_CCR: begin
            w[CCR_CBG_LSB +: 6] = cbg;
            w[CCR_CBC_LSB +: 2] = cbc;
            w[CCR_CFG_LSB +: 6] = cfg;
         end
         REG_SAR0: w = sar_0;
         REG_SAR1: w = sar_1;
         REG_MAR0: w = mar_0;
         REG_MAR1: w = mar_1;
         REG_CAR:  w = car;
         REG_HAR:  w = har;
         default:  w = '0;
      endcase
      return w;
   endfunction

   always_comb begin
      sel_word  = reg_word(rd_sel);
      addr_word = reg_word(addr);
   end

   // Old contents kept for a read that collides with a write
   always_ff @(posedge clk) begin
      if (|wr_en) begin
         pre_write_word <= addr_word;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_during_rd <= 1'b0;
      end else begin
         wr_during_rd <= devsel && rd && (|wr_en);
      end
   end

   assign rdata       = rd_pending ? (wr_during_rd ? pre_write_word : sel_word) : '0;
   assign rdata_valid = rd_pending;

endmodule

// ==== source/har_counter.sv ====
module har_counter
   import vdu_regmap_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        load,
   input  logic        incx,
   input  logic        incy,
   input  logic [15:0] load_value,
   output logic [15:0] har
);

   logic [8:0] y_count;
   logic [6:0] x_count;

   //////////////////////////////
   // Column counter, wraps at 128
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         x_count <= '0;
      end else if (load) begin
         x_count <= load_value[HAR_X_LSB +: 7];
      end else if (incx) begin
         x_count <= x_count + 7'd1;
      end
   end

   //////////////////////////////
   // Row counter, wraps at 512
   //////////////////////////////
   // No carry from x, the timer steps y on its own strobe
   always_ff @(posedge clk) begin
      if (reset) begin
         y_count <= '0;
      end else if (load) begin
         y_count <= load_value[HAR_Y_LSB +: 9];
      end else if (incy) begin
         y_count <= y_count + 9'd1;
      end
   end

   assign har[HAR_Y_LSB +: 9] = y_count;
   assign har[HAR_X_LSB +: 7] = x_count;

endmodule

// ==== source/banked_field.sv ====
module banked_field #(
   parameter type payload_t = logic [15:0]
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     wr_bank0,
   input  logic     wr_bank1,
   input  logic     altmode,
   input  payload_t wdata,
   output payload_t active,
   output payload_t bank0,
   output payload_t bank1
);

   always_ff @(posedge clk) begin
      if (reset) begin
         bank0 <= '0;
         bank1 <= '0;
      end else begin
         if (wr_bank0) begin
            bank0 <= wdata;
         end
         if (wr_bank1) begin
            bank1 <= wdata;
         end
      end
   end

   // Display side follows altmode with no delay
   assign active = altmode ? bank1 : bank0;

endmodule

// ==== source/reg_write_decode.sv ====
module reg_write_decode
   import vdu_regmap_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        devsel,
   input  logic        wr,
   input  logic        rd,
   input  logic [3:0]  addr,
   output logic [15:0] wr_en,
   output logic [3:0]  rd_sel,
   output logic        rd_pending
);

   logic wr_hit;
   logic rd_hit;

   // Addresses above the HAR are holes in the map
   assign wr_hit = devsel && wr && (addr <= REG_HAR);
   assign rd_hit = devsel && rd;

   always_comb begin
      wr_en = '0;
      if (wr_hit) begin
         wr_en[addr] = 1'b1;
      end
   end

   // Read address held for the read-back cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         rd_sel     <= '0;
         rd_pending <= 1'b0;
      end else begin
         rd_pending <= rd_hit;
         if (rd_hit) begin
            rd_sel <= addr;
         end
      end
   end

endmodule

// ==== source/vdu_timing_pkg.sv ====
package vdu_timing_pkg;

   // Character geometry, same order as MCR bits 5:0
   typedef struct packed {
      logic [1:0] cs2;
      logic       col40;
      logic [2:0] crh;
   } mode_field_t;

   // Fine scroll offsets
   // vertical in scanlines, horizontal in pixels
   typedef struct packed {
      logic [3:0] vscr;
      logic [2:0] hscr;
   } scroll_field_t;

endpackage

// ==== source/vdu_regmap_pkg.sv ====
package vdu_regmap_pkg;

   //////////////////////////////
   // Host register addresses
   //////////////////////////////
   localparam logic [3:0] REG_MCR0 = 4'd0;
   localparam logic [3:0] REG_MCR1 = 4'd1;
   localparam logic [3:0] REG_SCR0 = 4'd2;
   localparam logic [3:0] REG_SCR1 = 4'd3;
   localparam logic [3:0] REG_CCR  = 4'd4;
   localparam logic [3:0] REG_SAR0 = 4'd5;
   localparam logic [3:0] REG_SAR1 = 4'd6;
   localparam logic [3:0] REG_MAR0 = 4'd7;
   localparam logic [3:0] REG_MAR1 = 4'd8;
   localparam logic [3:0] REG_CAR  = 4'd9;
   localparam logic [3:0] REG_HAR  = 4'd10;

   //////////////////////////////
   // Field bit positions
   //////////////////////////////
   localparam int MCR_VDUEN    = 15;
   localparam int MCR_IRQSCL   = 7;
   localparam int MCR_IRQVS    = 6;
   // cs2 5:4, col40 3, crh 2:0 in both MCR words
   localparam int MCR_MODE_LSB = 0;
   localparam int MCR_SCL_LSB  = 8;
   localparam int MCR_SEN      = 7;
   localparam int SCR_VSCR_LSB = 4;
   localparam int SCR_HSCR_LSB = 0;
   localparam int CCR_CBG_LSB  = 8;
   localparam int CCR_CBC_LSB  = 6;
   localparam int CCR_CFG_LSB  = 0;
   localparam int HAR_Y_LSB    = 7;
   localparam int HAR_X_LSB    = 0;

endpackage
